/* src/calc_pkg.sv */
// Shared widths, codes and types; segments are active low, bit 7 is segment a and bit 0 is dp
package calc_pkg;

    localparam int digit_w          = 4;
    localparam int num_digits       = 3;
    // Display positions, the digits plus one for the sign
    localparam int num_pos          = num_digits + 1;

    localparam int num_ops          = 4;
    localparam int sw_w             = num_ops;
    localparam int op_add           = 0;
    localparam int op_sub           = 1;
    localparam int op_mul           = 2;
    localparam int op_div           = 3;

    localparam int result_w         = 16;
    localparam int result_max       = 999;
    localparam int bcd_steps        = result_w;
    localparam int bcd_conv_w       = num_digits * digit_w + result_w;

    localparam int scan_div_default = 1024;

    localparam logic [digit_w-1:0] code_blank = 4'd10;
    localparam logic [digit_w-1:0] code_minus = 4'd11;
    localparam int num_codes        = 12;

    typedef logic [7:0] seg_t;

    // Codes 0 to 9, then blank and minus
    localparam seg_t seg_table [num_codes] = '{
        8'b0000_0011, 8'b1001_1111, 8'b0010_0101, 8'b0000_1101,
        8'b1001_1001, 8'b0100_1001, 8'b0100_0001, 8'b0001_1111,
        8'b0000_0001, 8'b0001_1001, 8'b1111_1111, 8'b1111_1101
    };

    // Up is bit 0, mid is bit 4
    typedef struct packed {
        logic mid;
        logic right;
        logic left;
        logic down;
        logic up;
    } key_t;

    typedef struct packed {
        logic                                 sign;
        logic [num_digits-1:0][digit_w-1:0]   digit;
    } operand_t;

    typedef struct packed {
        logic                invalid;
        logic                neg;
        logic [result_w-1:0] mag;
    } exe_result_t;

    typedef struct packed {
        logic [num_pos-1:0][digit_w-1:0] code;
    } disp_word_t;

    typedef enum logic [4:0] {
        st_input_a = 5'b00001,
        st_input_b = 5'b00010,
        st_exe     = 5'b00100,
        st_convert = 5'b01000,
        st_display = 5'b10000
    } ctrl_state_t;

endpackage

/* src/key_entry.sv */
// Cursor stops at the sign on left and at the ones digit on right; keys are ignored while busy
`timescale 1ns/1ns

module key_entry (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic [4:0]             button,
    input  calc_pkg::ctrl_state_t  state,
    input  logic                   entry_clear,
    output calc_pkg::key_t         keys,
    output calc_pkg::operand_t     entry,
    output calc_pkg::disp_word_t   entry_word
);
    import calc_pkg::*;

    key_t     live;
    logic     key_en;
    logic     edit_en;
    // 0 ones, 1 tens, 2 hundreds, 3 sign
    logic [1:0] cursor;
    operand_t entry_q;

    function automatic logic [digit_w-1:0] step_digit(input logic [digit_w-1:0] d,
                                                     input logic up);
        if (up) begin
            return (d == 4'd9) ? 4'd0 : d + 4'd1;
        end
        return (d == 4'd0) ? 4'd9 : d - 4'd1;
    endfunction

    assign key_en  = state inside {st_input_a, st_input_b, st_display};
    assign edit_en = state inside {st_input_a, st_input_b};

    // Lowest set bit wins, up first
    assign live = key_en ? key_t'(button & (~button + 5'd1)) : '0;
    assign keys = live;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cursor  <= '0;
            entry_q <= '0;
        end else if (entry_clear) begin
            cursor  <= '0;
            entry_q <= '0;
        end else if (edit_en) begin
            if (live.left && cursor != 2'(num_digits)) begin
                cursor <= cursor + 2'd1;
            end else if (live.right && cursor != 2'd0) begin
                cursor <= cursor - 2'd1;
            end else if (live.up || live.down) begin
                if (cursor == 2'(num_digits)) begin
                    entry_q.sign <= ~entry_q.sign;
                end else begin
                    entry_q.digit[cursor] <= step_digit(entry_q.digit[cursor], live.up);
                end
            end
        end
    end

    assign entry = entry_q;

    always_comb begin
        for (int i = 0; i < num_digits; i++) begin
            entry_word.code[i] = entry_q.digit[i];
        end
        entry_word.code[num_digits] = entry_q.sign ? code_minus : code_blank;
    end

    // Wrap logic must never leave a non-decimal code behind
    a_digit_range: assert property (@(posedge clk) disable iff (!arst_n)
        entry_q.digit[0] <= 4'd9 && entry_q.digit[1] <= 4'd9 && entry_q.digit[2] <= 4'd9);

endmodule

/* src/calc_ctrl.sv */
// Mid is the only key used here; switches are captured together with operand B
`timescale 1ns/1ns

module calc_ctrl (
    input  logic                      clk,
    input  logic                      arst_n,
    input  calc_pkg::key_t            keys,
    input  logic [calc_pkg::sw_w-1:0] switches,
    input  calc_pkg::operand_t        entry,
    input  logic                      bcd_done,
    output calc_pkg::ctrl_state_t     state,
    output logic                      entry_clear,
    output logic                      exe_start,
    output calc_pkg::operand_t        op_a,
    output calc_pkg::operand_t        op_b,
    output logic [calc_pkg::sw_w-1:0] op_sw
);
    import calc_pkg::*;

    ctrl_state_t state_next;
    logic        accept_a;
    logic        accept_b;

    assign accept_a = (state == st_input_a) && keys.mid;
    assign accept_b = (state == st_input_b) && keys.mid;

    always_comb begin
        state_next = state;
        case (state)
            st_input_a: begin
                if (keys.mid) begin
                    state_next = st_input_b;
                end
            end
            st_input_b: begin
                if (keys.mid) begin
                    state_next = st_exe;
                end
            end
            st_exe:     state_next = st_convert;
            st_convert: begin
                if (bcd_done) begin
                    state_next = st_display;
                end
            end
            st_display: begin
                if (keys.mid) begin
                    state_next = st_input_a;
                end
            end
            default:    state_next = st_input_a;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state       <= st_input_a;
            entry_clear <= 1'b0;
            exe_start   <= 1'b0;
        end else begin
            state       <= state_next;
            // Mid is only forwarded in the entry and display states
            entry_clear <= keys.mid;
            exe_start   <= accept_b;
        end
    end

    always_ff @(posedge clk) begin
        if (accept_a) begin
            op_a <= entry;
        end
        if (accept_b) begin
            op_b  <= entry;
            op_sw <= switches;
        end
    end

    a_state_onehot: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot(state));

endmodule

/* src/alu_exec.sv */
// Product range is checked at double width so a wrapped 16-bit product is still flagged invalid
`timescale 1ns/1ns

module alu_exec (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      exe_start,
    input  calc_pkg::operand_t        op_a,
    input  calc_pkg::operand_t        op_b,
    input  logic [calc_pkg::sw_w-1:0] op_sw,
    output calc_pkg::exe_result_t     exe_res,
    output logic                      exe_valid
);
    import calc_pkg::*;

    logic signed [result_w-1:0]   a_val;
    logic signed [result_w-1:0]   b_val;
    logic signed [2*result_w-1:0] a_w;
    logic signed [2*result_w-1:0] b_w;
    logic signed [2*result_w-1:0] wide;
    logic [2*result_w-1:0]        wide_mag;
    logic [sw_w-1:0]              op_sel;
    logic                         invalid;

    // d0 + 10*d1 + 100*d2 by shifts
    function automatic logic signed [result_w-1:0] to_bin(input operand_t op);
        logic [result_w-1:0] d0;
        logic [result_w-1:0] d1;
        logic [result_w-1:0] d2;
        logic [result_w-1:0] mag;
        d0  = result_w'(op.digit[0]);
        d1  = result_w'(op.digit[1]);
        d2  = result_w'(op.digit[2]);
        mag = d0 + (d1 << 3) + (d1 << 1) + (d2 << 6) + (d2 << 5) + (d2 << 2);
        return op.sign ? -mag : mag;
    endfunction

    assign a_val = to_bin(op_a);
    assign b_val = to_bin(op_b);
    assign a_w   = a_val;
    assign b_w   = b_val;

    // Lowest set switch
    assign op_sel = op_sw & (~op_sw + sw_w'(1));

    always_comb begin
        wide = '0;
        if (op_sel[op_add]) begin
            wide = a_w + b_w;
        end
        if (op_sel[op_sub]) begin
            wide = a_w - b_w;
        end
        if (op_sel[op_mul]) begin
            wide = a_w * b_w;
        end
        if (op_sel[op_div] && b_val != '0) begin
            wide = a_w / b_w;
        end
    end

    assign wide_mag = wide[2*result_w-1] ? -wide : wide;
    assign invalid  = ~|op_sel
                    | (op_sel[op_div] && b_val == '0)
                    | (wide_mag > result_max);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            exe_valid <= 1'b0;
        end else begin
            exe_valid <= exe_start;
        end
    end

    always_ff @(posedge clk) begin
        if (exe_start) begin
            exe_res.invalid <= invalid;
            exe_res.neg     <= wide[2*result_w-1] & ~invalid;
            exe_res.mag     <= wide_mag[result_w-1:0];
        end
    end

endmodule

/* src/bin_to_bcd.sv */
// Only three BCD digits are kept, enough for any valid magnitude; done is high in the last step
`timescale 1ns/1ns

module bin_to_bcd (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  start,
    input  calc_pkg::exe_result_t exe_res,
    output calc_pkg::disp_word_t  bcd_word,
    output logic                  bcd_invalid,
    output logic                  done
);
    import calc_pkg::*;

    logic                           busy_q;
    logic [$clog2(bcd_steps+1)-1:0] step_q;
    logic [bcd_conv_w-1:0]          conv_q;
    logic [bcd_conv_w-1:0]          conv_next;
    logic                           neg_q;

    function automatic logic [bcd_conv_w-1:0] shift_add3(input logic [bcd_conv_w-1:0] cur);
        logic [bcd_conv_w-1:0] adj;
        adj = cur;
        for (int i = 0; i < num_digits; i++) begin
            if (adj[result_w + i*digit_w +: digit_w] >= 4'd5) begin
                adj[result_w + i*digit_w +: digit_w] = adj[result_w + i*digit_w +: digit_w] + 4'd3;
            end
        end
        return adj << 1;
    endfunction

    // Minus goes one place left of the highest digit shown
    function automatic disp_word_t form_word(input logic [num_digits*digit_w-1:0] bcd,
                                             input logic neg);
        disp_word_t w;
        int         top;
        top = 0;
        for (int i = 1; i < num_digits; i++) begin
            if (bcd[i*digit_w +: digit_w] != '0) begin
                top = i;
            end
        end
        for (int i = 0; i < num_pos; i++) begin
            w.code[i] = code_blank;
        end
        for (int i = 0; i < num_digits; i++) begin
            if (i <= top) begin
                w.code[i] = bcd[i*digit_w +: digit_w];
            end
        end
        if (neg) begin
            w.code[top+1] = code_minus;
        end
        return w;
    endfunction

    // Load and first shift happen together
    assign conv_next = shift_add3(start ? bcd_conv_w'(exe_res.mag) : conv_q);
    assign done      = busy_q && (step_q == $bits(step_q)'(bcd_steps - 1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy_q      <= 1'b0;
            step_q      <= '0;
            bcd_invalid <= 1'b0;
            bcd_word    <= '0;
        end else begin
            if (start) begin
                busy_q      <= 1'b1;
                step_q      <= $bits(step_q)'(1);
                bcd_invalid <= exe_res.invalid;
            end else if (busy_q) begin
                step_q <= step_q + 1'b1;
                if (done) begin
                    busy_q <= 1'b0;
                end
            end
            if (done) begin
                bcd_word <= form_word(conv_next[result_w +: num_digits*digit_w], neg_q);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            neg_q <= exe_res.neg;
        end
        if (start || busy_q) begin
            conv_q <= conv_next;
        end
    end

    a_step_bound: assert property (@(posedge clk) disable iff (!arst_n)
        step_q <= bcd_steps);

endmodule

/* src/seg_scan.sv */
// Anodes are active low; position 0 is the rightmost digit; the scan holds while dark
`timescale 1ns/1ns

module seg_scan #(
    parameter int scan_div = calc_pkg::scan_div_default
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  calc_pkg::ctrl_state_t state,
    input  calc_pkg::disp_word_t  entry_word,
    input  calc_pkg::disp_word_t  bcd_word,
    input  logic                  bcd_invalid,
    output logic [3:0]            digit_an,
    output calc_pkg::seg_t        digit_seg
);
    import calc_pkg::*;

    logic [$clog2(scan_div)-1:0] div_q;
    logic                        tick;
    logic [1:0]                  pos_q;
    logic                        in_entry;
    logic                        show_result;
    logic                        scan_en;
    disp_word_t                  word;
    logic [digit_w-1:0]          code;

    assign tick = (div_q == $bits(div_q)'(scan_div - 1));

    assign in_entry    = state inside {st_input_a, st_input_b};
    assign show_result = (state == st_display) && !bcd_invalid;
    assign scan_en     = in_entry || show_result;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            div_q <= '0;
            pos_q <= '0;
        end else begin
            div_q <= tick ? '0 : div_q + 1'b1;
            if (tick && scan_en) begin
                pos_q <= pos_q + 2'd1;
            end
        end
    end

    always_comb begin
        if (in_entry) begin
            word = entry_word;
        end else if (show_result) begin
            word = bcd_word;
        end else begin
            for (int i = 0; i < num_pos; i++) begin
                word.code[i] = code_blank;
            end
        end
    end

    assign code      = word.code[pos_q];
    assign digit_an  = scan_en ? ~(4'b0001 << pos_q) : 4'b1111;
    assign digit_seg = (code < num_codes) ? seg_table[code] : seg_table[code_blank];

endmodule

/* src/calc_top.sv */
// Buttons must be debounced single-cycle strobes; switches are sampled when B is accepted
`timescale 1ns/1ns

module calc_top #(
    parameter int scan_div = calc_pkg::scan_div_default
) (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic [4:0]                button,
    input  logic [calc_pkg::sw_w-1:0] switches,
    output logic [3:0]                digit_an,
    output calc_pkg::seg_t            digit_seg,
    output logic                      exe_done
);
    import calc_pkg::*;

    key_t                keys;
    ctrl_state_t         state;
    operand_t            entry;
    disp_word_t          entry_word;
    logic                entry_clear;
    logic                exe_start;
    operand_t            op_a;
    operand_t            op_b;
    logic [sw_w-1:0]     op_sw;
    exe_result_t         exe_res;
    logic                exe_valid;
    disp_word_t          bcd_word;
    logic                bcd_invalid;
    logic                bcd_done;

    key_entry u_key_entry (
        .clk         (clk),
        .arst_n      (arst_n),
        .button      (button),
        .state       (state),
        .entry_clear (entry_clear),
        .keys        (keys),
        .entry       (entry),
        .entry_word  (entry_word)
    );

    calc_ctrl u_calc_ctrl (
        .clk         (clk),
        .arst_n      (arst_n),
        .keys        (keys),
        .switches    (switches),
        .entry       (entry),
        .bcd_done    (bcd_done),
        .state       (state),
        .entry_clear (entry_clear),
        .exe_start   (exe_start),
        .op_a        (op_a),
        .op_b        (op_b),
        .op_sw       (op_sw)
    );

    alu_exec u_alu_exec (
        .clk       (clk),
        .arst_n    (arst_n),
        .exe_start (exe_start),
        .op_a      (op_a),
        .op_b      (op_b),
        .op_sw     (op_sw),
        .exe_res   (exe_res),
        .exe_valid (exe_valid)
    );

    bin_to_bcd u_bin_to_bcd (
        .clk         (clk),
        .arst_n      (arst_n),
        .start       (exe_valid),
        .exe_res     (exe_res),
        .bcd_word    (bcd_word),
        .bcd_invalid (bcd_invalid),
        .done        (bcd_done)
    );

    seg_scan #(
        .scan_div (scan_div)
    ) u_seg_scan (
        .clk         (clk),
        .arst_n      (arst_n),
        .state       (state),
        .entry_word  (entry_word),
        .bcd_word    (bcd_word),
        .bcd_invalid (bcd_invalid),
        .digit_an    (digit_an),
        .digit_seg   (digit_seg)
    );

    assign exe_done = bcd_done;

endmodule

/* dv/tb_clk_gen.sv */
// Clock starts low; reset is released on a falling edge after reset_cycles full periods
`timescale 1ns/1ns

module tb_clk_gen #(
    parameter int period       = 20,
    parameter int reset_cycles = 3
) (
    output logic clk,
    output logic arst_n
);
    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    initial begin
        arst_n = 1'b0;
        #(period * reset_cycles) arst_n = 1'b1;
    end

endmodule

/* dv/calc_tb.sv */
// Runs calc_top with a short scan divider; display reads take a full 16-cycle scan
`timescale 1ns/1ns

module calc_tb;
    import calc_pkg::*;

    localparam int clk_period = 20;
    // Cycles from the edge that samples the accepting mid to the edge that sees exe_done
    localparam int done_lat   = 17;
    localparam int num_runs   = 46;
    localparam int run_cycles = 200;
    localparam int watchdog_ns = (num_runs * run_cycles + 500) * clk_period;
    localparam int unsigned rand_seed = 32'h2e1a815d;
    localparam logic [4:0] key_mid = 5'b10000;
    localparam disp_word_t cleared_word = '{code: '{code_blank, 4'd0, 4'd0, 4'd0}};

    logic        clk;
    logic        arst_n;
    logic [4:0]  button;
    logic [3:0]  switches;
    logic [3:0]  digit_an;
    seg_t        digit_seg;
    logic        exe_done;

    logic        mid_b;
    logic [done_lat-1:0] mid_hist;
    logic        disp_chk;
    logic [16:0] disp_exp;
    logic [16:0] disp_got;
    string       tname;
    int          value_errs;
    int          timing_errs;
    int          other_errs;

    // Entry model: cursor 0 ones to 3 sign
    int          cur_pos;
    int          digs [3];
    bit          neg;

    tb_clk_gen #(.period(clk_period), .reset_cycles(3)) u_clk (.clk(clk), .arst_n(arst_n));

    calc_top #(.scan_div(4)) uut (
        .clk       (clk),
        .arst_n    (arst_n),
        .button    (button),
        .switches  (switches),
        .digit_an  (digit_an),
        .digit_seg (digit_seg),
        .exe_done  (exe_done)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mid_hist <= '0;
        end else begin
            mid_hist <= {mid_hist[done_lat-2:0], mid_b};
        end
    end

    a_done_latency: assert property (@(posedge clk) disable iff (!arst_n)
        exe_done == mid_hist[done_lat-1])
        else begin
            timing_errs++;
            $display("exe_done in %s did not line up with the accepting mid", tname);
        end

    a_display: assert property (@(posedge clk) disable iff (!arst_n)
        disp_chk |-> disp_got == disp_exp)
        else begin
            value_errs++;
            $display("ERR %s expected %h actual %h", tname, disp_exp, disp_got);
        end

    function automatic logic [digit_w-1:0] seg_to_code(input seg_t s);
        for (int i = 0; i < num_codes; i++) begin
            if (seg_table[i] == s) begin
                return digit_w'(i);
            end
        end
        return 4'hf;
    endfunction

    function automatic disp_word_t model_word();
        disp_word_t w;
        for (int i = 0; i < 3; i++) begin
            w.code[i] = digit_w'(digs[i]);
        end
        w.code[3] = neg ? code_minus : code_blank;
        return w;
    endfunction

    function automatic int model_value();
        int mag;
        mag = digs[2] * 100 + digs[1] * 10 + digs[0];
        return neg ? -mag : mag;
    endfunction

    // Leading zeros dark, minus just left of the top digit
    function automatic disp_word_t number_word(input int r);
        disp_word_t w;
        int mag;
        int top;
        int d [3];
        mag  = (r < 0) ? -r : r;
        d[0] = mag % 10;
        d[1] = (mag / 10) % 10;
        d[2] = mag / 100;
        top  = (d[2] != 0) ? 2 : ((d[1] != 0) ? 1 : 0);
        for (int i = 0; i < 4; i++) begin
            w.code[i] = (i <= top) ? digit_w'(d[i]) : code_blank;
        end
        if (r < 0) begin
            w.code[top+1] = code_minus;
        end
        return w;
    endfunction

    function automatic int lowest_op(input logic [3:0] sw);
        for (int i = 0; i < 4; i++) begin
            if (sw[i]) begin
                return i;
            end
        end
        return -1;
    endfunction

    task automatic clear_model();
        cur_pos = 0;
        neg     = 1'b0;
        for (int i = 0; i < 3; i++) begin
            digs[i] = 0;
        end
    endtask

    task automatic press_key(input logic [4:0] key, input bit accept_b);
        @(posedge clk);
        button <= key;
        mid_b  <= accept_b;
        @(posedge clk);
        button <= '0;
        mid_b  <= 1'b0;
    endtask

    // 0 up, 1 down, 2 left, 3 right
    task automatic apply_key(input int k);
        if (k < 2 && cur_pos == 3) begin
            neg = !neg;
        end else if (k == 0) begin
            digs[cur_pos] = (digs[cur_pos] + 1) % 10;
        end else if (k == 1) begin
            digs[cur_pos] = (digs[cur_pos] + 9) % 10;
        end else if (k == 2 && cur_pos < 3) begin
            cur_pos++;
        end else if (k == 3 && cur_pos > 0) begin
            cur_pos--;
        end
        press_key(5'b00001 << k, 1'b0);
    endtask

    task automatic press_random_keys(input int n);
        repeat (n) apply_key(int'($urandom % 4));
    endtask

    task automatic enter_value(input int v);
        int mag;
        int t [3];
        int diff;
        mag  = (v < 0) ? -v : v;
        t[0] = mag % 10;
        t[1] = (mag / 10) % 10;
        t[2] = mag / 100;
        while (cur_pos > 0) apply_key(3);
        for (int i = 0; i < 3; i++) begin
            diff = (t[i] - digs[i] + 10) % 10;
            if (diff <= 5) begin
                repeat (diff) apply_key(0);
            end else begin
                repeat (10 - diff) apply_key(1);
            end
            apply_key(2);
        end
        if (neg != (v < 0)) begin
            apply_key(0);
        end
    endtask

    task automatic read_display(output bit dark, output disp_word_t w);
        dark = 1'b1;
        for (int p = 0; p < 4; p++) begin
            w.code[p] = code_blank;
        end
        @(posedge clk);
        repeat (16) begin
            @(negedge clk);
            for (int p = 0; p < 4; p++) begin
                if (!digit_an[p]) begin
                    dark      = 1'b0;
                    w.code[p] = seg_to_code(digit_seg);
                end
            end
        end
    endtask

    task automatic check_display(input string name, input bit exp_dark, input disp_word_t exp_w);
        bit         dark;
        disp_word_t w;
        read_display(dark, w);
        tname    = name;
        disp_exp = {exp_dark, exp_w};
        disp_got = {dark, w};
        disp_chk = 1'b1;
        @(negedge clk);
        disp_chk = 1'b0;
    endtask

    task automatic wait_exe_done(input string name);
        int n;
        n = 0;
        while (!exe_done && n < 40) begin
            @(negedge clk);
            n++;
        end
        if (!exe_done) begin
            other_errs++;
            $display("exe_done never arrived in %s", name);
        end
    endtask

    task automatic enter_operand(input string name, input bit by_keys, input int v,
                                 output int val);
        if (by_keys) begin
            press_random_keys(8 + int'($urandom % 16));
        end else begin
            enter_value(v);
        end
        check_display(name, 1'b0, model_word());
        val = model_value();
    endtask

    task automatic do_operation(input string name, input bit by_keys, input int a, input int b,
                                input logic [3:0] sw);
        int av;
        int bv;
        int r;
        bit bad;
        enter_operand({name, " a"}, by_keys, a, av);
        press_key(key_mid, 1'b0);
        clear_model();
        enter_operand({name, " b"}, by_keys, b, bv);
        @(posedge clk);
        switches <= sw;
        press_key(key_mid, 1'b1);
        clear_model();
        wait_exe_done(name);
        bad = 1'b0;
        r   = 0;
        case (lowest_op(sw))
            0: r = av + bv;
            1: r = av - bv;
            2: r = av * bv;
            3: begin
                if (bv == 0) begin
                    bad = 1'b1;
                end else begin
                    r = av / bv;
                end
            end
            default: bad = 1'b1;
        endcase
        if (r > result_max || r < -result_max) begin
            bad = 1'b1;
        end
        check_display(name, bad, bad ? disp_word_t'(16'haaaa) : number_word(r));
        press_key(key_mid, 1'b0);
        check_display({name, " clear"}, 1'b0, cleared_word);
    endtask

    initial begin
        #(watchdog_ns);
        $display("watchdog expired before the tests finished");
        $display("** FAIL **");
        $finish;
    end

    initial begin
        button      <= '0;
        switches    <= '0;
        mid_b       <= 1'b0;
        disp_chk    = 1'b0;
        disp_exp    = '0;
        disp_got    = '0;
        value_errs  = 0;
        timing_errs = 0;
        other_errs  = 0;
        tname       = "reset";
        void'($urandom(rand_seed));
        clear_model();
        @(posedge arst_n);
        check_display("reset", 1'b0, cleared_word);
        for (int n = 0; n < 40; n++) begin
            do_operation($sformatf("random_%0d", n), n % 2 == 0,
                         int'($urandom % 121) - 60, int'($urandom % 121) - 60,
                         4'($urandom % 16));
        end
        do_operation("div_zero", 1'b0, 5, 0, 4'b1000);
        do_operation("no_switch", 1'b0, 12, 3, 4'b0000);
        do_operation("range_mul", 1'b0, 500, 3, 4'b0100);
        do_operation("prio_sub", 1'b0, 12, 5, 4'b1110);
        do_operation("prio_mul", 1'b0, -12, 5, 4'b1100);
        do_operation("trunc_div", 1'b0, -7, 2, 4'b1000);
        repeat (2) @(posedge clk);
        $display("errors: %0d value, %0d timing, %0d other", value_errs, timing_errs, other_errs);
        if (value_errs + timing_errs + other_errs == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* src.f */
src/calc_pkg.sv
src/key_entry.sv
src/calc_ctrl.sv
src/alu_exec.sv
src/bin_to_bcd.sv
src/seg_scan.sv
src/calc_top.sv
dv/tb_clk_gen.sv
dv/calc_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f src.f --top-module calc_tb -o calc_sim
./obj_dir/calc_sim > sim.log 2>&1
cat sim.log

if grep -qx '\*\* PASS \*\*' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
